// ==== source/mcwh_pkg.sv ====
package mcwh_pkg;

  // Wormhole link
  localparam int FLIT_W = 16;
  localparam int COORD_W = 4;
  localparam int LEN_W = 3;
  localparam int RSV_W = 2;
  localparam int HDR_W = RSV_W + 2 * COORD_W + LEN_W;

  // Flits per packet on each network
  localparam int REQ_FLITS = 4;
  localparam int RESP_FLITS = 2;
  localparam int REQ_PKT_W = REQ_FLITS * FLIT_W;
  localparam int RESP_PKT_W = RESP_FLITS * FLIT_W;

  // Manycore payloads
  localparam int MC_REQ_W = 48;
  localparam int MC_RESP_W = 16;

  // Zero bits between header and payload
  localparam int REQ_PAD_W = REQ_PKT_W - HDR_W - MC_REQ_W;
  localparam int RESP_PAD_W = RESP_PKT_W - HDR_W - MC_RESP_W;

  localparam int FIFO_LG_DEPTH = 3;

  typedef enum logic {
    NET_REQ,
    NET_RESP
  } net_e;

  typedef enum logic {
    SER_IDLE,
    SER_SEND
  } ser_state_e;

  function automatic int pkt_flits(input net_e net);
    int flits;
    flits = (net == NET_REQ) ? REQ_FLITS : RESP_FLITS;
    return flits;
  endfunction

  // Header from the top: reserved, x, y, len
  function automatic logic [HDR_W-1:0] mk_hdr(
    input logic [COORD_W-1:0] x,
    input logic [COORD_W-1:0] y,
    input logic [LEN_W-1:0] len
  );
    logic [HDR_W-1:0] hdr;
    hdr = {{RSV_W{1'b0}}, x, y, len};
    return hdr;
  endfunction

endpackage

// ==== source/mcwh_sync.sv ====
module mcwh_sync (
  input  logic manycore_clk_i,
  input  logic rst_n_i,
  input  logic en_i,
  output logic manycore_rst_n_o,
  output logic manycore_en_o
);

  logic [1:0] rst_sync_r;
  logic [1:0] en_sync_r;

  // Assert at once, release after two manycore edges
  always_ff @(posedge manycore_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync_r <= 2'b00;
    end else begin
      rst_sync_r <= {rst_sync_r[0], 1'b1};
    end
  end

  // Enable level crossing into manycore domain
  always_ff @(posedge manycore_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_sync_r <= 2'b00;
    end else begin
      en_sync_r <= {en_sync_r[0], en_i};
    end
  end

  assign manycore_rst_n_o = rst_sync_r[1];
  assign manycore_en_o = en_sync_r[1];

endmodule

// ==== source/mcwh_async_fifo.sv ====
module mcwh_async_fifo #(
  parameter int WIDTH = 16,
  parameter int LG_DEPTH = 3
) (
  // Write side
  input  logic             w_clk_i,
  input  logic             w_rst_n_i,
  input  logic             w_enq_i,
  input  logic [WIDTH-1:0] w_data_i,
  output logic             w_full_o,

  // Read side
  input  logic             r_clk_i,
  input  logic             r_rst_n_i,
  input  logic             r_deq_i,
  output logic [WIDTH-1:0] r_data_o,
  output logic             r_valid_o
);

  logic [WIDTH-1:0] mem [2**LG_DEPTH];

  // One extra pointer bit tells full from empty
  logic [LG_DEPTH:0] w_bin_r;
  logic [LG_DEPTH:0] w_bin_next;
  logic [LG_DEPTH:0] w_gray_r;
  logic [LG_DEPTH:0] r_bin_r;
  logic [LG_DEPTH:0] r_bin_next;
  logic [LG_DEPTH:0] r_gray_r;

  // Gray pointers seen from the other side
  logic [LG_DEPTH:0] r_gray_w1_r;
  logic [LG_DEPTH:0] r_gray_w2_r;
  logic [LG_DEPTH:0] w_gray_r1_r;
  logic [LG_DEPTH:0] w_gray_r2_r;

  assign w_bin_next = w_bin_r + 1'b1;
  assign r_bin_next = r_bin_r + 1'b1;

  always_ff @(posedge w_clk_i or negedge w_rst_n_i) begin
    if (!w_rst_n_i) begin
      w_bin_r <= '0;
      w_gray_r <= '0;
    end else if (w_enq_i) begin
      w_bin_r <= w_bin_next;
      w_gray_r <= w_bin_next ^ (w_bin_next >> 1);
    end
  end

  always_ff @(posedge w_clk_i) begin
    if (w_enq_i) begin
      mem[w_bin_r[LG_DEPTH-1:0]] <= w_data_i;
    end
  end

  always_ff @(posedge w_clk_i or negedge w_rst_n_i) begin
    if (!w_rst_n_i) begin
      r_gray_w1_r <= '0;
      r_gray_w2_r <= '0;
    end else begin
      r_gray_w1_r <= r_gray_r;
      r_gray_w2_r <= r_gray_w1_r;
    end
  end

  // Full when the top two gray bits differ and the rest match
  assign w_full_o = (w_gray_r == {~r_gray_w2_r[LG_DEPTH -: 2], r_gray_w2_r[LG_DEPTH-2:0]});

  always_ff @(posedge r_clk_i or negedge r_rst_n_i) begin
    if (!r_rst_n_i) begin
      r_bin_r <= '0;
      r_gray_r <= '0;
    end else if (r_deq_i) begin
      r_bin_r <= r_bin_next;
      r_gray_r <= r_bin_next ^ (r_bin_next >> 1);
    end
  end

  always_ff @(posedge r_clk_i or negedge r_rst_n_i) begin
    if (!r_rst_n_i) begin
      w_gray_r1_r <= '0;
      w_gray_r2_r <= '0;
    end else begin
      w_gray_r1_r <= w_gray_r;
      w_gray_r2_r <= w_gray_r1_r;
    end
  end

  // Head entry shown directly
  assign r_valid_o = (r_gray_r != w_gray_r2_r);
  assign r_data_o = mem[r_bin_r[LG_DEPTH-1:0]];

endmodule

// ==== source/mcwh_flit_serializer.sv ====
module mcwh_flit_serializer #(
  parameter int ELS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic                                  in_valid_i,
  input  logic [ELS*mcwh_pkg::FLIT_W-1:0]       in_data_i,
  output logic                                  in_ready_o,

  output logic                                  out_valid_o,
  output logic [mcwh_pkg::FLIT_W-1:0]           out_data_o,
  input  logic                                  out_ready_i
);

  import mcwh_pkg::*;

  ser_state_e state_r;
  logic [ELS*FLIT_W-1:0] data_r;
  logic [$clog2(ELS)-1:0] cnt_r;
  logic taken;
  logic last;

  assign taken = out_valid_o & out_ready_i;
  assign last = (int'(cnt_r) == ELS - 1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= SER_IDLE;
      cnt_r <= '0;
    end else begin
      case (state_r)
        SER_IDLE: begin
          if (in_valid_i) begin
            state_r <= SER_SEND;
            cnt_r <= '0;
          end
        end
        SER_SEND: begin
          if (taken) begin
            cnt_r <= cnt_r + 1'b1;
            if (last) begin
              state_r <= SER_IDLE;
            end
          end
        end
        default: state_r <= SER_IDLE;
      endcase
    end
  end

  // Shift up so the next flit sits on top
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_r <= in_data_i;
    end else if (taken) begin
      data_r <= data_r << FLIT_W;
    end
  end

  assign in_ready_o = (state_r == SER_IDLE);
  assign out_valid_o = (state_r == SER_SEND);
  assign out_data_o = data_r[ELS*FLIT_W-1 -: FLIT_W];

endmodule

// ==== source/mcwh_flit_deserializer.sv ====
module mcwh_flit_deserializer #(
  parameter int ELS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic                                  in_valid_i,
  input  logic [mcwh_pkg::FLIT_W-1:0]           in_data_i,
  output logic                                  in_ready_o,

  output logic                                  out_valid_o,
  output logic [ELS*mcwh_pkg::FLIT_W-1:0]       out_data_o,
  input  logic                                  out_ready_i
);

  import mcwh_pkg::*;

  logic [ELS*FLIT_W-1:0] data_r;
  logic [$clog2(ELS)-1:0] cnt_r;
  logic full_r;
  logic flit_in;

  assign flit_in = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_r <= '0;
      full_r <= 1'b0;
    end else begin
      if (flit_in) begin
        if (int'(cnt_r) == ELS - 1) begin
          cnt_r <= '0;
          full_r <= 1'b1;
        end else begin
          cnt_r <= cnt_r + 1'b1;
        end
      end
      // Packet leaves, start collecting the next one
      if (out_valid_o && out_ready_i) begin
        full_r <= 1'b0;
      end
    end
  end

  // First flit ends up on top after ELS shifts
  always_ff @(posedge clk_i) begin
    if (flit_in) begin
      data_r <= {data_r[(ELS-1)*FLIT_W-1:0], in_data_i};
    end
  end

  assign in_ready_o = ~full_r;
  assign out_valid_o = full_r;
  assign out_data_o = data_r;

endmodule

// ==== source/mcwh_link_bridge.sv ====
module mcwh_link_bridge (
  // Wormhole domain
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             en_i,
  input  logic [mcwh_pkg::COORD_W-1:0]     dest_x_i,
  input  logic [mcwh_pkg::COORD_W-1:0]     dest_y_i,

  // Manycore domain
  input  logic                             manycore_clk_i,
  output logic                             manycore_rst_n_o,
  output logic                             manycore_en_o,

  input  logic                             req_in_valid_i,
  input  logic [mcwh_pkg::MC_REQ_W-1:0]    req_in_data_i,
  output logic                             req_in_ready_o,
  output logic                             req_out_valid_o,
  output logic [mcwh_pkg::MC_REQ_W-1:0]    req_out_data_o,
  input  logic                             req_out_ready_i,

  input  logic                             resp_in_valid_i,
  input  logic [mcwh_pkg::MC_RESP_W-1:0]   resp_in_data_i,
  output logic                             resp_in_ready_o,
  output logic                             resp_out_valid_o,
  output logic [mcwh_pkg::MC_RESP_W-1:0]   resp_out_data_o,
  input  logic                             resp_out_ready_i,

  // Wormhole flit channels
  input  logic                             wh_req_in_valid_i,
  input  logic [mcwh_pkg::FLIT_W-1:0]      wh_req_in_data_i,
  output logic                             wh_req_in_ready_o,
  output logic                             wh_req_out_valid_o,
  output logic [mcwh_pkg::FLIT_W-1:0]      wh_req_out_data_o,
  input  logic                             wh_req_out_ready_i,

  input  logic                             wh_resp_in_valid_i,
  input  logic [mcwh_pkg::FLIT_W-1:0]      wh_resp_in_data_i,
  output logic                             wh_resp_in_ready_o,
  output logic                             wh_resp_out_valid_o,
  output logic [mcwh_pkg::FLIT_W-1:0]      wh_resp_out_data_o,
  input  logic                             wh_resp_out_ready_i
);

  import mcwh_pkg::*;

  logic [REQ_PKT_W-1:0] req_pkt;
  logic [RESP_PKT_W-1:0] resp_pkt;

  // Serializer to outbound FIFO
  logic req_ser_valid;
  logic resp_ser_valid;
  logic [FLIT_W-1:0] req_ser_data;
  logic [FLIT_W-1:0] resp_ser_data;
  logic req_ob_full;
  logic resp_ob_full;

  // Inbound FIFO to deserializer
  logic req_ib_full;
  logic resp_ib_full;
  logic req_ib_valid;
  logic resp_ib_valid;
  logic [FLIT_W-1:0] req_ib_data;
  logic [FLIT_W-1:0] resp_ib_data;
  logic req_des_ready;
  logic resp_des_ready;
  logic [REQ_PKT_W-1:0] req_des_data;
  logic [RESP_PKT_W-1:0] resp_des_data;

  mcwh_sync sync0 (
    .manycore_clk_i  (manycore_clk_i),
    .rst_n_i         (rst_n_i),
    .en_i            (en_i),
    .manycore_rst_n_o(manycore_rst_n_o),
    .manycore_en_o   (manycore_en_o)
  );

  // Header on top, payload at the bottom, zeros between
  assign req_pkt = {mk_hdr(dest_x_i, dest_y_i, LEN_W'(pkt_flits(NET_REQ) - 1)),
                    {REQ_PAD_W{1'b0}}, req_in_data_i};
  assign resp_pkt = {mk_hdr(dest_x_i, dest_y_i, LEN_W'(pkt_flits(NET_RESP) - 1)),
                     {RESP_PAD_W{1'b0}}, resp_in_data_i};

  // Request network
  mcwh_flit_serializer #(.ELS(pkt_flits(NET_REQ))) req_ser (
    .clk_i      (manycore_clk_i),
    .rst_n_i    (manycore_rst_n_o),
    .in_valid_i (req_in_valid_i),
    .in_data_i  (req_pkt),
    .in_ready_o (req_in_ready_o),
    .out_valid_o(req_ser_valid),
    .out_data_o (req_ser_data),
    .out_ready_i(~req_ob_full)
  );

  mcwh_async_fifo #(.WIDTH(FLIT_W), .LG_DEPTH(FIFO_LG_DEPTH)) req_ob_fifo (
    .w_clk_i  (manycore_clk_i),
    .w_rst_n_i(manycore_rst_n_o),
    .w_enq_i  (req_ser_valid & ~req_ob_full),
    .w_data_i (req_ser_data),
    .w_full_o (req_ob_full),
    .r_clk_i  (clk_i),
    .r_rst_n_i(rst_n_i),
    .r_deq_i  (wh_req_out_valid_o & wh_req_out_ready_i),
    .r_data_o (wh_req_out_data_o),
    .r_valid_o(wh_req_out_valid_o)
  );

  mcwh_async_fifo #(.WIDTH(FLIT_W), .LG_DEPTH(FIFO_LG_DEPTH)) req_ib_fifo (
    .w_clk_i  (clk_i),
    .w_rst_n_i(rst_n_i),
    .w_enq_i  (wh_req_in_valid_i & ~req_ib_full),
    .w_data_i (wh_req_in_data_i),
    .w_full_o (req_ib_full),
    .r_clk_i  (manycore_clk_i),
    .r_rst_n_i(manycore_rst_n_o),
    .r_deq_i  (req_ib_valid & req_des_ready),
    .r_data_o (req_ib_data),
    .r_valid_o(req_ib_valid)
  );

  mcwh_flit_deserializer #(.ELS(pkt_flits(NET_REQ))) req_des (
    .clk_i      (manycore_clk_i),
    .rst_n_i    (manycore_rst_n_o),
    .in_valid_i (req_ib_valid),
    .in_data_i  (req_ib_data),
    .in_ready_o (req_des_ready),
    .out_valid_o(req_out_valid_o),
    .out_data_o (req_des_data),
    .out_ready_i(req_out_ready_i)
  );

  // Response network
  mcwh_flit_serializer #(.ELS(pkt_flits(NET_RESP))) resp_ser (
    .clk_i      (manycore_clk_i),
    .rst_n_i    (manycore_rst_n_o),
    .in_valid_i (resp_in_valid_i),
    .in_data_i  (resp_pkt),
    .in_ready_o (resp_in_ready_o),
    .out_valid_o(resp_ser_valid),
    .out_data_o (resp_ser_data),
    .out_ready_i(~resp_ob_full)
  );

  mcwh_async_fifo #(.WIDTH(FLIT_W), .LG_DEPTH(FIFO_LG_DEPTH)) resp_ob_fifo (
    .w_clk_i  (manycore_clk_i),
    .w_rst_n_i(manycore_rst_n_o),
    .w_enq_i  (resp_ser_valid & ~resp_ob_full),
    .w_data_i (resp_ser_data),
    .w_full_o (resp_ob_full),
    .r_clk_i  (clk_i),
    .r_rst_n_i(rst_n_i),
    .r_deq_i  (wh_resp_out_valid_o & wh_resp_out_ready_i),
    .r_data_o (wh_resp_out_data_o),
    .r_valid_o(wh_resp_out_valid_o)
  );

  mcwh_async_fifo #(.WIDTH(FLIT_W), .LG_DEPTH(FIFO_LG_DEPTH)) resp_ib_fifo (
    .w_clk_i  (clk_i),
    .w_rst_n_i(rst_n_i),
    .w_enq_i  (wh_resp_in_valid_i & ~resp_ib_full),
    .w_data_i (wh_resp_in_data_i),
    .w_full_o (resp_ib_full),
    .r_clk_i  (manycore_clk_i),
    .r_rst_n_i(manycore_rst_n_o),
    .r_deq_i  (resp_ib_valid & resp_des_ready),
    .r_data_o (resp_ib_data),
    .r_valid_o(resp_ib_valid)
  );

  mcwh_flit_deserializer #(.ELS(pkt_flits(NET_RESP))) resp_des (
    .clk_i      (manycore_clk_i),
    .rst_n_i    (manycore_rst_n_o),
    .in_valid_i (resp_ib_valid),
    .in_data_i  (resp_ib_data),
    .in_ready_o (resp_des_ready),
    .out_valid_o(resp_out_valid_o),
    .out_data_o (resp_des_data),
    .out_ready_i(resp_out_ready_i)
  );

  assign wh_req_in_ready_o = ~req_ib_full;
  assign wh_resp_in_ready_o = ~resp_ib_full;

  // Incoming header is dropped
  assign req_out_data_o = req_des_data[MC_REQ_W-1:0];
  assign resp_out_data_o = resp_des_data[MC_RESP_W-1:0];

endmodule

// ==== test/tb_mcwh_checker.sv ====
module tb_mcwh_checker (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             en_i,
  input  logic [mcwh_pkg::COORD_W-1:0]     dest_x_i,
  input  logic [mcwh_pkg::COORD_W-1:0]     dest_y_i,
  input  logic                             manycore_clk_i,
  input  logic                             manycore_rst_n_o,
  input  logic                             manycore_en_o,

  input  logic                             req_in_valid_i,
  input  logic [mcwh_pkg::MC_REQ_W-1:0]    req_in_data_i,
  input  logic                             req_in_ready_o,
  input  logic                             req_out_valid_o,
  input  logic [mcwh_pkg::MC_REQ_W-1:0]    req_out_data_o,
  input  logic                             req_out_ready_i,
  input  logic                             resp_in_valid_i,
  input  logic [mcwh_pkg::MC_RESP_W-1:0]   resp_in_data_i,
  input  logic                             resp_in_ready_o,
  input  logic                             resp_out_valid_o,
  input  logic [mcwh_pkg::MC_RESP_W-1:0]   resp_out_data_o,
  input  logic                             resp_out_ready_i,

  input  logic                             wh_req_in_valid_i,
  input  logic [mcwh_pkg::FLIT_W-1:0]      wh_req_in_data_i,
  input  logic                             wh_req_in_ready_o,
  input  logic                             wh_req_out_valid_o,
  input  logic [mcwh_pkg::FLIT_W-1:0]      wh_req_out_data_o,
  input  logic                             wh_req_out_ready_i,
  input  logic                             wh_resp_in_valid_i,
  input  logic [mcwh_pkg::FLIT_W-1:0]      wh_resp_in_data_i,
  input  logic                             wh_resp_in_ready_o,
  input  logic                             wh_resp_out_valid_o,
  input  logic [mcwh_pkg::FLIT_W-1:0]      wh_resp_out_data_o,
  input  logic                             wh_resp_out_ready_i,

  output int                               err_cnt_o,
  output int                               oth_cnt_o,
  output int                               pend_wh_req_o,
  output int                               pend_wh_resp_o,
  output int                               pend_mc_req_o,
  output int                               pend_mc_resp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import mcwh_pkg::*;

  localparam int EXP_DEPTH = 512;

  // Expected streams, each written by one clock domain and read by the other
  logic [FLIT_W-1:0] wh_req_exp [EXP_DEPTH];
  logic [FLIT_W-1:0] wh_resp_exp [EXP_DEPTH];
  logic [MC_REQ_W-1:0] mc_req_exp [EXP_DEPTH];
  logic [MC_RESP_W-1:0] mc_resp_exp [EXP_DEPTH];
  int wh_req_wr = 0;
  int wh_req_rd = 0;
  int wh_resp_wr = 0;
  int wh_resp_rd = 0;
  int mc_req_wr = 0;
  int mc_req_rd = 0;
  int mc_resp_wr = 0;
  int mc_resp_rd = 0;

  // Inbound flits collected into packets
  logic [REQ_PKT_W-1:0] req_acc = '0;
  logic [RESP_PKT_W-1:0] resp_acc = '0;
  int req_cnt = 0;
  int resp_cnt = 0;

  int err_clk = 0;
  int err_mc = 0;
  int oth_clk = 0;
  int oth_mc = 0;
  int rst_cycles = 0;
  logic en_seen = 1'b0;
  int en_age = 0;

  assign err_cnt_o = err_clk + err_mc;
  assign oth_cnt_o = oth_clk + oth_mc;
  assign pend_wh_req_o = wh_req_wr - wh_req_rd;
  assign pend_wh_resp_o = wh_resp_wr - wh_resp_rd;
  assign pend_mc_req_o = mc_req_wr - mc_req_rd;
  assign pend_mc_resp_o = mc_resp_wr - mc_resp_rd;

  // Header in the top bits: reserved zero, x, y, flit count minus one
  function automatic logic [REQ_PKT_W-1:0] frame_packet(
    input int flits,
    input logic [MC_REQ_W-1:0] payload,
    input logic [COORD_W-1:0] x,
    input logic [COORD_W-1:0] y
  );
    logic [HDR_W-1:0] hdr;
    logic [REQ_PKT_W-1:0] pkt;
    hdr = {{RSV_W{1'b0}}, x, y, LEN_W'(flits - 1)};
    pkt = REQ_PKT_W'(payload);
    pkt = pkt | (REQ_PKT_W'(hdr) << (flits * FLIT_W - HDR_W));
    return pkt;
  endfunction

  // Flit k counted from the most significant end
  function automatic logic [FLIT_W-1:0] flit_of(
    input logic [REQ_PKT_W-1:0] pkt,
    input int flits,
    input int k
  );
    return FLIT_W'(pkt >> ((flits - 1 - k) * FLIT_W));
  endfunction

  always @(posedge manycore_clk_i) begin : mc_side
    logic [REQ_PKT_W-1:0] pkt;
    if (req_in_valid_i && req_in_ready_o) begin
      pkt = frame_packet(REQ_FLITS, req_in_data_i, dest_x_i, dest_y_i);
      for (int k = 0; k < REQ_FLITS; k++) begin
        wh_req_exp[wh_req_wr] = flit_of(pkt, REQ_FLITS, k);
        wh_req_wr++;
      end
    end
    if (resp_in_valid_i && resp_in_ready_o) begin
      pkt = frame_packet(RESP_FLITS, MC_REQ_W'(resp_in_data_i), dest_x_i, dest_y_i);
      for (int k = 0; k < RESP_FLITS; k++) begin
        wh_resp_exp[wh_resp_wr] = flit_of(pkt, RESP_FLITS, k);
        wh_resp_wr++;
      end
    end
    if (req_out_valid_o && req_out_ready_i) begin
      if (mc_req_rd == mc_req_wr) begin
        oth_mc++;
        $display("At %0t a request reached the manycore side that was never sent", $time);
      end else begin
        if (req_out_data_o != mc_req_exp[mc_req_rd]) begin
          err_mc++;
          $display("Fail %0t: manycore request payload %h, expected %h", $time,
                   req_out_data_o, mc_req_exp[mc_req_rd]);
        end
        mc_req_rd++;
      end
    end
    if (resp_out_valid_o && resp_out_ready_i) begin
      if (mc_resp_rd == mc_resp_wr) begin
        oth_mc++;
        $display("At %0t a response reached the manycore side that was never sent", $time);
      end else begin
        if (resp_out_data_o != mc_resp_exp[mc_resp_rd]) begin
          err_mc++;
          $display("Fail %0t: manycore response payload %h, expected %h", $time,
                   resp_out_data_o, mc_resp_exp[mc_resp_rd]);
        end
        mc_resp_rd++;
      end
    end
    if (!manycore_rst_n_o && (req_out_valid_o || resp_out_valid_o)) begin
      err_mc++;
      $display("Fail %0t: manycore output valid before reset release", $time);
    end
    // Enable level once it has been stable for three manycore cycles
    if (en_i != en_seen) begin
      en_seen = en_i;
      en_age = 0;
    end else if (en_age < 3) begin
      en_age++;
    end
    if (manycore_rst_n_o && en_age >= 3 && manycore_en_o != en_i) begin
      err_mc++;
      $display("Fail %0t: manycore_en_o is %b, en_i is %b", $time, manycore_en_o, en_i);
    end
  end

  always @(posedge clk_i) begin : wh_side
    if (!rst_n_i) begin
      rst_cycles++;
      if (rst_cycles > 2 && (manycore_rst_n_o || manycore_en_o || wh_req_out_valid_o ||
          wh_resp_out_valid_o || req_out_valid_o || resp_out_valid_o)) begin
        err_clk++;
        $display("Fail %0t: outputs not held low during reset", $time);
      end
    end
    if (wh_req_in_valid_i && wh_req_in_ready_o) begin
      req_acc = (req_acc << FLIT_W) | REQ_PKT_W'(wh_req_in_data_i);
      req_cnt++;
      if (req_cnt == REQ_FLITS) begin
        mc_req_exp[mc_req_wr] = req_acc[MC_REQ_W-1:0];
        mc_req_wr++;
        req_cnt = 0;
      end
    end
    if (wh_resp_in_valid_i && wh_resp_in_ready_o) begin
      resp_acc = (resp_acc << FLIT_W) | RESP_PKT_W'(wh_resp_in_data_i);
      resp_cnt++;
      if (resp_cnt == RESP_FLITS) begin
        mc_resp_exp[mc_resp_wr] = resp_acc[MC_RESP_W-1:0];
        mc_resp_wr++;
        resp_cnt = 0;
      end
    end
    if (wh_req_out_valid_o && wh_req_out_ready_i) begin
      if (wh_req_rd == wh_req_wr) begin
        oth_clk++;
        $display("At %0t a request flit left on the wormhole side with none pending", $time);
      end else begin
        if (wh_req_out_data_o != wh_req_exp[wh_req_rd]) begin
          err_clk++;
          $display("Fail %0t: wormhole request flit %h, expected %h", $time,
                   wh_req_out_data_o, wh_req_exp[wh_req_rd]);
        end
        wh_req_rd++;
      end
    end
    if (wh_resp_out_valid_o && wh_resp_out_ready_i) begin
      if (wh_resp_rd == wh_resp_wr) begin
        oth_clk++;
        $display("At %0t a response flit left on the wormhole side with none pending", $time);
      end else begin
        if (wh_resp_out_data_o != wh_resp_exp[wh_resp_rd]) begin
          err_clk++;
          $display("Fail %0t: wormhole response flit %h, expected %h", $time,
                   wh_resp_out_data_o, wh_resp_exp[wh_resp_rd]);
        end
        wh_resp_rd++;
      end
    end
  end

endmodule

// ==== test/tb_mcwh_link_bridge.sv ====
module tb_mcwh_link_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  import mcwh_pkg::*;

  localparam int PKTS = 16;
  localparam int WAIT_LIMIT = 500;
  localparam int DRAIN_LIMIT = 4000;

  int seed = 42;
  int timeout_cnt = 0;

  logic clk_i = 1'b0;
  logic rst_n_i = 1'b0;
  logic en_i = 1'b0;
  logic [COORD_W-1:0] dest_x_i = '0;
  logic [COORD_W-1:0] dest_y_i = '0;
  logic manycore_clk_i = 1'b1;
  logic manycore_rst_n_o;
  logic manycore_en_o;

  logic req_in_valid_i = 1'b0;
  logic [MC_REQ_W-1:0] req_in_data_i = '0;
  logic req_in_ready_o;
  logic req_out_valid_o;
  logic [MC_REQ_W-1:0] req_out_data_o;
  logic req_out_ready_i = 1'b0;
  logic resp_in_valid_i = 1'b0;
  logic [MC_RESP_W-1:0] resp_in_data_i = '0;
  logic resp_in_ready_o;
  logic resp_out_valid_o;
  logic [MC_RESP_W-1:0] resp_out_data_o;
  logic resp_out_ready_i = 1'b0;

  logic wh_req_in_valid_i = 1'b0;
  logic [FLIT_W-1:0] wh_req_in_data_i = '0;
  logic wh_req_in_ready_o;
  logic wh_req_out_valid_o;
  logic [FLIT_W-1:0] wh_req_out_data_o;
  logic wh_req_out_ready_i = 1'b0;
  logic wh_resp_in_valid_i = 1'b0;
  logic [FLIT_W-1:0] wh_resp_in_data_i = '0;
  logic wh_resp_in_ready_o;
  logic wh_resp_out_valid_o;
  logic [FLIT_W-1:0] wh_resp_out_data_o;
  logic wh_resp_out_ready_i = 1'b0;

  int err_cnt_o;
  int oth_cnt_o;
  int pend_wh_req_o;
  int pend_wh_resp_o;
  int pend_mc_req_o;
  int pend_mc_resp_o;

  always #4 clk_i = ~clk_i;
  // Manycore edges on multiples of 10 ns, never on a drive time of the other domain
  always #5 manycore_clk_i = ~manycore_clk_i;

  mcwh_link_bridge dut0 (.*);

  tb_mcwh_checker chk0 (.*);

  // Random back-pressure, ready about three cycles in four
  always @(posedge clk_i) begin
    #1;
    wh_req_out_ready_i = (($random(seed) & 3) != 0);
    wh_resp_out_ready_i = (($random(seed) & 3) != 0);
  end

  always @(posedge manycore_clk_i) begin
    #1;
    req_out_ready_i = (($random(seed) & 3) != 0);
    resp_out_ready_i = (($random(seed) & 3) != 0);
  end

  task automatic wait_clk(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_mc(input int n);
    repeat (n) begin
      @(posedge manycore_clk_i);
      #1;
    end
  endtask

  function automatic logic mc_ready(input net_e net);
    return (net == NET_REQ) ? req_in_ready_o : resp_in_ready_o;
  endfunction

  function automatic logic wh_ready(input net_e net);
    return (net == NET_REQ) ? wh_req_in_ready_o : wh_resp_in_ready_o;
  endfunction

  // Ready seen after an edge holds until the next edge
  task automatic mc_send(input net_e net, input logic [MC_REQ_W-1:0] data);
    int waited;
    waited = 0;
    if (net == NET_REQ) begin
      req_in_valid_i = 1'b1;
      req_in_data_i = data;
    end else begin
      resp_in_valid_i = 1'b1;
      resp_in_data_i = data[MC_RESP_W-1:0];
    end
    while (!mc_ready(net) && waited < WAIT_LIMIT) begin
      wait_mc(1);
      waited++;
    end
    if (!mc_ready(net)) begin
      timeout_cnt++;
      $display("Timeout: manycore %s input never became ready", net.name());
    end else begin
      wait_mc(1);
    end
    if (net == NET_REQ) begin
      req_in_valid_i = 1'b0;
    end else begin
      resp_in_valid_i = 1'b0;
    end
  endtask

  task automatic wh_send(input net_e net, input logic [FLIT_W-1:0] flit);
    int waited;
    waited = 0;
    if (net == NET_REQ) begin
      wh_req_in_valid_i = 1'b1;
      wh_req_in_data_i = flit;
    end else begin
      wh_resp_in_valid_i = 1'b1;
      wh_resp_in_data_i = flit;
    end
    while (!wh_ready(net) && waited < WAIT_LIMIT) begin
      wait_clk(1);
      waited++;
    end
    if (!wh_ready(net)) begin
      timeout_cnt++;
      $display("Timeout: wormhole %s input never became ready", net.name());
    end else begin
      wait_clk(1);
    end
    if (net == NET_REQ) begin
      wh_req_in_valid_i = 1'b0;
    end else begin
      wh_resp_in_valid_i = 1'b0;
    end
  endtask

  task automatic mc_stream(input net_e net);
    logic [63:0] rnd;
    int gap;
    wait_mc(1);
    for (int i = 0; i < PKTS; i++) begin
      gap = $random(seed) & 3;
      wait_mc(gap);
      rnd = {$random(seed), $random(seed)};
      mc_send(net, rnd[MC_REQ_W-1:0]);
    end
  endtask

  // Whole packets with a random header, most significant flit first
  task automatic wh_stream(input net_e net);
    logic [63:0] rnd;
    logic [REQ_PKT_W-1:0] pkt;
    int flits;
    int gap;
    flits = (net == NET_REQ) ? REQ_FLITS : RESP_FLITS;
    wait_clk(1);
    for (int i = 0; i < PKTS; i++) begin
      rnd = {$random(seed), $random(seed)};
      if (net == NET_REQ) begin
        pkt = REQ_PKT_W'(rnd[MC_REQ_W-1:0]);
      end else begin
        pkt = REQ_PKT_W'(rnd[MC_RESP_W-1:0]);
      end
      pkt = pkt | (REQ_PKT_W'({{RSV_W{1'b0}}, rnd[51:48], rnd[55:52], LEN_W'(flits - 1)})
                   << (flits * FLIT_W - HDR_W));
      for (int k = 0; k < flits; k++) begin
        wh_send(net, FLIT_W'(pkt >> ((flits - 1 - k) * FLIT_W)));
        gap = $random(seed) % 3;
        wait_clk(gap < 0 ? -gap : gap);
      end
    end
  endtask

  task automatic drain_streams();
    int waited;
    waited = 0;
    wait_clk(1);
    while ((pend_wh_req_o + pend_wh_resp_o + pend_mc_req_o + pend_mc_resp_o) != 0 &&
           waited < DRAIN_LIMIT) begin
      wait_clk(1);
      waited++;
    end
    if ((pend_wh_req_o + pend_wh_resp_o + pend_mc_req_o + pend_mc_resp_o) != 0) begin
      timeout_cnt++;
      if (pend_wh_req_o != 0)
        $display("Timeout: wormhole request output stalled, %0d flits left", pend_wh_req_o);
      if (pend_wh_resp_o != 0)
        $display("Timeout: wormhole response output stalled, %0d flits left", pend_wh_resp_o);
      if (pend_mc_req_o != 0)
        $display("Timeout: manycore request output stalled, %0d packets left", pend_mc_req_o);
      if (pend_mc_resp_o != 0)
        $display("Timeout: manycore response output stalled, %0d packets left", pend_mc_resp_o);
    end
  endtask

  task automatic run_phase(input logic [COORD_W-1:0] x, input logic [COORD_W-1:0] y);
    dest_x_i = x;
    dest_y_i = y;
    fork
      mc_stream(NET_REQ);
      mc_stream(NET_RESP);
      wh_stream(NET_REQ);
      wh_stream(NET_RESP);
    join
    drain_streams();
  endtask

  initial begin
    int waited;
    waited = 0;
    wait_clk(16);
    rst_n_i = 1'b1;
    while (!manycore_rst_n_o && waited < 20) begin
      wait_clk(1);
      waited++;
    end
    if (!manycore_rst_n_o) begin
      timeout_cnt++;
      $display("Timeout: manycore reset was never released");
    end
    en_i = 1'b1;
    wait_clk(8);

    run_phase(4'd3, 4'd5);

    // Enable drop and return, and a new destination, while idle
    en_i = 1'b0;
    wait_clk(8);
    en_i = 1'b1;
    wait_clk(8);
    run_phase(4'd9, 4'd12);

    $display("Checks done: %0d mismatches, %0d other failures", err_cnt_o,
             oth_cnt_o + timeout_cnt);
    if (err_cnt_o == 0 && oth_cnt_o + timeout_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
source/mcwh_pkg.sv
source/mcwh_sync.sv
source/mcwh_async_fifo.sv
source/mcwh_flit_serializer.sv
source/mcwh_flit_deserializer.sv
source/mcwh_link_bridge.sv
test/tb_mcwh_checker.sv
test/tb_mcwh_link_bridge.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --timescale 1ns/1ps --top-module tb_mcwh_link_bridge \
  -f sources.f --Mdir obj_dir -o tb_mcwh_link_bridge
./obj_dir/tb_mcwh_link_bridge > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0
